// File: hw/alut_reg_pkg.sv
//----------------------------------------
// alut register map
// apb offsets, command codes and the
// status bit positions
//----------------------------------------
package alut_reg_pkg;

   // apb offsets, 7-bit address
   localparam logic [6:0] AL_FRM_D_ADDR_L   = 7'h00;
   localparam logic [6:0] AL_FRM_D_ADDR_U   = 7'h04;
   localparam logic [6:0] AL_FRM_S_ADDR_L   = 7'h08;
   localparam logic [6:0] AL_FRM_S_ADDR_U   = 7'h0C;
   localparam logic [6:0] AL_S_PORT         = 7'h10;
   localparam logic [6:0] AL_D_PORT         = 7'h14;   // read only
   localparam logic [6:0] AL_MAC_ADDR_L     = 7'h18;
   localparam logic [6:0] AL_MAC_ADDR_U     = 7'h1C;
   localparam logic [6:0] AL_COMMAND        = 7'h20;   // self clearing
   localparam logic [6:0] AL_BB_AGE         = 7'h24;
   localparam logic [6:0] AL_DIV_CLK        = 7'h28;
   localparam logic [6:0] AL_STATUS         = 7'h2C;
   localparam logic [6:0] AL_CUR_TIME       = 7'h30;
   localparam logic [6:0] AL_LST_INV_ADDR_L = 7'h34;
   localparam logic [6:0] AL_LST_INV_ADDR_U = 7'h38;
   localparam logic [6:0] AL_LST_INV_PORT   = 7'h3C;

   // command codes
   localparam logic [1:0] AL_CMD_AGE   = 2'b01;   // age sweep
   localparam logic [1:0] AL_CMD_CHECK = 2'b10;   // learn source, look up dest

   // status bits
   localparam int AL_ST_ACTIVE = 0;
   localparam int AL_ST_INVAL  = 1;
   localparam int AL_ST_REUSED = 2;

endpackage

// File: hw/alut_entry_pkg.sv
//----------------------------------------
// alut table entry
// table geometry, entry layout and the
// destination port mask values
//----------------------------------------
package alut_entry_pkg;

   localparam int AL_DEPTH = 8;   // direct mapped entries
   localparam int AL_IDX_W = 3;   // low address bits as index
   localparam int AL_PORTS = 4;

   typedef logic [47:0] mac_t;
   typedef logic [1:0]  port_t;
   typedef logic [AL_PORTS:0] dport_t;   // [3:0] egress, [4] switch itself

   // 83 bits
   typedef struct packed {
      logic        valid;
      mac_t        addr;
      port_t       port;
      logic [31:0] stamp;   // curr_time when learned
   } alut_entry_t;

   localparam dport_t AL_DP_SELF  = 5'b10000;
   localparam dport_t AL_DP_FLOOD = 5'b01111;   // source port masked off later

endpackage

// File: hw/alut_mem_if.sv
//----------------------------------------
// alut table access
// index, write strobe and entry data
// between controller and table memory
//----------------------------------------
interface alut_mem_if;

   logic [alut_entry_pkg::AL_IDX_W-1:0] idx;     // read/write index
   logic                                wr;      // write at this edge
   alut_entry_pkg::alut_entry_t         wdata;
   alut_entry_pkg::alut_entry_t         rdata;   // entry at idx of last cycle

   modport ctrl (output idx, output wr, output wdata, input rdata);
   modport mem  (input idx, input wr, input wdata, output rdata);

endinterface

// File: hw/alut_reg_bank.sv
//----------------------------------------
// alut apb register bank
// frame/switch addresses, age and divider
// registers, self clearing command, read
// mux and last invalidated capture
//----------------------------------------
module alut_reg_bank
(
   input  logic                           pclk1,
   input  logic                           n_p_reset1,
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [6:0]                     paddr,
   input  logic [31:0]                    pwdata,
   output logic [31:0]                    prdata,
   input  logic [31:0]                    curr_time,
   input  logic                           add_check_active,
   input  logic                           inval_in_prog,
   input  logic                           reused,
   input  alut_entry_pkg::dport_t         d_port,
   input  alut_entry_pkg::mac_t           lst_inv_addr_nrm,
   input  alut_entry_pkg::port_t          lst_inv_port_nrm,
   input  alut_entry_pkg::mac_t           lst_inv_addr_cmd,
   input  alut_entry_pkg::port_t          lst_inv_port_cmd,
   output alut_entry_pkg::mac_t           mac_addr,
   output alut_entry_pkg::mac_t           d_addr,
   output alut_entry_pkg::mac_t           s_addr,
   output alut_entry_pkg::port_t          s_port,
   output logic [31:0]                    best_bfr_age,
   output logic [7:0]                     div_clk,
   output logic [1:0]                     command,
   output logic                           clear_reused
);

   logic                  read_en;
   logic                  write_en;
   logic [31:0]           frm_d_addr_l;
   logic [15:0]           frm_d_addr_u;
   logic [31:0]           frm_s_addr_l;
   logic [15:0]           frm_s_addr_u;
   logic [31:0]           mac_addr_l;
   logic [15:0]           mac_addr_u;
   alut_entry_pkg::mac_t  lst_inv_addr;
   alut_entry_pkg::port_t lst_inv_port;
   logic [31:0]           status;

   assign read_en  = psel & ~penable & ~pwrite;   // setup phase
   assign write_en = psel & penable & pwrite;     // access phase

   assign d_addr   = {frm_d_addr_u, frm_d_addr_l};
   assign s_addr   = {frm_s_addr_u, frm_s_addr_l};
   assign mac_addr = {mac_addr_u, mac_addr_l};

   // status read acknowledges reuse, but not mid check
   assign clear_reused = read_en & (paddr == alut_reg_pkg::AL_STATUS) & ~add_check_active;

   always_comb
   begin
      status = '0;
      status[alut_reg_pkg::AL_ST_ACTIVE] = add_check_active;
      status[alut_reg_pkg::AL_ST_INVAL]  = inval_in_prog;
      status[alut_reg_pkg::AL_ST_REUSED] = reused;
   end

   //----------------------------------------
   // writable registers
   //----------------------------------------
   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
      begin
         frm_d_addr_l <= '0;
         frm_d_addr_u <= '0;
         frm_s_addr_l <= '0;
         frm_s_addr_u <= '0;
         s_port       <= '0;
         mac_addr_l   <= '0;
         mac_addr_u   <= '0;
         best_bfr_age <= '1;   // nothing ages by default
         div_clk      <= '0;
      end
      else if (write_en)
      begin
         case (paddr)
            alut_reg_pkg::AL_FRM_D_ADDR_L : frm_d_addr_l <= pwdata;
            alut_reg_pkg::AL_FRM_D_ADDR_U : frm_d_addr_u <= pwdata[15:0];
            alut_reg_pkg::AL_FRM_S_ADDR_L : frm_s_addr_l <= pwdata;
            alut_reg_pkg::AL_FRM_S_ADDR_U : frm_s_addr_u <= pwdata[15:0];
            alut_reg_pkg::AL_S_PORT       : s_port       <= pwdata[1:0];
            alut_reg_pkg::AL_MAC_ADDR_L   : mac_addr_l   <= pwdata;
            alut_reg_pkg::AL_MAC_ADDR_U   : mac_addr_u   <= pwdata[15:0];
            alut_reg_pkg::AL_BB_AGE       : best_bfr_age <= pwdata;
            alut_reg_pkg::AL_DIV_CLK      : div_clk      <= pwdata[7:0];
            default                       : ;   // read only or unmapped
         endcase
      end
   end

   // one cycle pulse, never held
   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
         command <= 2'b00;
      else if (command != 2'b00)
         command <= 2'b00;
      else if (write_en && (paddr == alut_reg_pkg::AL_COMMAND))
         command <= pwdata[1:0];
   end

   //----------------------------------------
   // read mux, zero outside setup phase
   //----------------------------------------
   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
         prdata <= '0;
      else if (read_en)
      begin
         case (paddr)
            alut_reg_pkg::AL_FRM_D_ADDR_L   : prdata <= frm_d_addr_l;
            alut_reg_pkg::AL_FRM_D_ADDR_U   : prdata <= {16'd0, frm_d_addr_u};
            alut_reg_pkg::AL_FRM_S_ADDR_L   : prdata <= frm_s_addr_l;
            alut_reg_pkg::AL_FRM_S_ADDR_U   : prdata <= {16'd0, frm_s_addr_u};
            alut_reg_pkg::AL_S_PORT         : prdata <= {30'd0, s_port};
            alut_reg_pkg::AL_D_PORT         : prdata <= {27'd0, d_port};
            alut_reg_pkg::AL_MAC_ADDR_L     : prdata <= mac_addr_l;
            alut_reg_pkg::AL_MAC_ADDR_U     : prdata <= {16'd0, mac_addr_u};
            alut_reg_pkg::AL_BB_AGE         : prdata <= best_bfr_age;
            alut_reg_pkg::AL_DIV_CLK        : prdata <= {24'd0, div_clk};
            alut_reg_pkg::AL_STATUS         : prdata <= status;
            alut_reg_pkg::AL_CUR_TIME       : prdata <= curr_time;
            alut_reg_pkg::AL_LST_INV_ADDR_L : prdata <= lst_inv_addr[31:0];
            alut_reg_pkg::AL_LST_INV_ADDR_U : prdata <= {16'd0, lst_inv_addr[47:32]};
            alut_reg_pkg::AL_LST_INV_PORT   : prdata <= {30'd0, lst_inv_port};
            default                         : prdata <= '0;   // command reads 0 too
         endcase
      end
      else
         prdata <= '0;
   end

   // reuse eviction outranks the age sweep
   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
      begin
         lst_inv_addr <= '0;
         lst_inv_port <= '0;
      end
      else if (reused)
      begin
         lst_inv_addr <= lst_inv_addr_nrm;
         lst_inv_port <= lst_inv_port_nrm;
      end
      else if (inval_in_prog)
      begin
         lst_inv_addr <= lst_inv_addr_cmd;
         lst_inv_port <= lst_inv_port_cmd;
      end
   end

   //----------------------------------------
   // bus checks
   //----------------------------------------
   a_no_rd_wr : assert property (@(posedge pclk1) disable iff (!n_p_reset1)
      !(read_en && write_en));

   a_cmd_pulse : assert property (@(posedge pclk1) disable iff (!n_p_reset1)
      (command != 2'b00) |=> (command == 2'b00));

endmodule

// File: hw/alut_ctrl.sv
//----------------------------------------
// alut controller
// sequences check frame (read dest,
// compare, read source, write source) and
// the two cycle per entry age sweep
//----------------------------------------
module alut_ctrl
(
   input  logic                   pclk1,
   input  logic                   n_p_reset1,
   input  logic [1:0]             command,
   input  alut_entry_pkg::mac_t   d_addr,
   input  alut_entry_pkg::mac_t   s_addr,
   input  alut_entry_pkg::port_t  s_port,
   input  logic [31:0]            best_bfr_age,
   input  logic [31:0]            curr_time,
   input  logic                   clear_reused,
   input  alut_entry_pkg::dport_t dport_next,
   input  logic                   aged,
   alut_mem_if.ctrl               mem_bus,
   output logic                   add_check_active,
   output logic                   inval_in_prog,
   output logic                   reused,
   output alut_entry_pkg::mac_t   lst_inv_addr_nrm,
   output alut_entry_pkg::port_t  lst_inv_port_nrm,
   output alut_entry_pkg::mac_t   lst_inv_addr_cmd,
   output alut_entry_pkg::port_t  lst_inv_port_cmd,
   output alut_entry_pkg::dport_t d_port
);

   typedef enum logic [2:0] {
      ST_IDLE, ST_RD_D, ST_CMP, ST_RD_S, ST_WR_S, ST_AGE_RD, ST_AGE_WR
   } state_t;

   state_t                              state;
   logic [alut_entry_pkg::AL_IDX_W-1:0] sweep_idx;
   alut_entry_pkg::dport_t              dport_hold;   // mask until check ends
   alut_entry_pkg::mac_t                inv_addr_q;
   alut_entry_pkg::port_t               inv_port_q;
   logic                                age_off;
   logic                                inv_now;
   logic                                reuse_now;

   assign add_check_active = (state == ST_RD_D) | (state == ST_CMP) |
                             (state == ST_RD_S) | (state == ST_WR_S);
   assign inval_in_prog    = (state == ST_AGE_RD) | (state == ST_AGE_WR);

   assign age_off   = &best_bfr_age;   // max age, nothing can expire
   assign inv_now   = (state == ST_AGE_WR) & mem_bus.rdata.valid & aged & ~age_off;
   assign reuse_now = (state == ST_WR_S) & mem_bus.rdata.valid &
                      (mem_bus.rdata.addr != s_addr);   // slot owned by another addr

   // entry being dropped now, else the last one
   assign lst_inv_addr_cmd = inv_now ? mem_bus.rdata.addr : inv_addr_q;
   assign lst_inv_port_cmd = inv_now ? mem_bus.rdata.port : inv_port_q;

   //----------------------------------------
   // fsm
   //----------------------------------------
   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
      begin
         state     <= ST_IDLE;
         sweep_idx <= '0;
      end
      else
      begin
         case (state)
            ST_IDLE :
               if (command == alut_reg_pkg::AL_CMD_CHECK)
                  state <= ST_RD_D;
               else if (command == alut_reg_pkg::AL_CMD_AGE)
                  state <= ST_AGE_RD;
            ST_RD_D   : state <= ST_CMP;
            ST_CMP    : state <= ST_RD_S;
            ST_RD_S   : state <= ST_WR_S;
            ST_AGE_RD : state <= ST_AGE_WR;
            ST_AGE_WR :
            begin
               sweep_idx <= sweep_idx + 1'b1;   // wraps to 0 after last
               state     <= (sweep_idx == '1) ? ST_IDLE : ST_AGE_RD;
            end
            default   : state <= ST_IDLE;   // ST_WR_S ends the check
         endcase
      end
   end

   always_ff @(posedge pclk1)
   begin
      if (state == ST_CMP)
         dport_hold <= dport_next;
   end

   // result shows as active drops
   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
         d_port <= '0;
      else if (state == ST_WR_S)
         d_port <= dport_hold;
   end

   // sticky reuse flag, first evicted entry kept
   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
      begin
         reused           <= 1'b0;
         lst_inv_addr_nrm <= '0;
         lst_inv_port_nrm <= '0;
      end
      else if (clear_reused)
         reused <= 1'b0;
      else if (reuse_now && !reused)
      begin
         reused           <= 1'b1;
         lst_inv_addr_nrm <= mem_bus.rdata.addr;
         lst_inv_port_nrm <= mem_bus.rdata.port;
      end
   end

   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
      begin
         inv_addr_q <= '0;
         inv_port_q <= '0;
      end
      else if (inv_now)
      begin
         inv_addr_q <= mem_bus.rdata.addr;
         inv_port_q <= mem_bus.rdata.port;
      end
   end

   //----------------------------------------
   // table access
   //----------------------------------------
   always_comb
   begin
      mem_bus.idx   = d_addr[alut_entry_pkg::AL_IDX_W-1:0];
      mem_bus.wr    = 1'b0;
      mem_bus.wdata = '{valid: 1'b1, addr: s_addr, port: s_port, stamp: curr_time};
      case (state)
         ST_RD_S   : mem_bus.idx = s_addr[alut_entry_pkg::AL_IDX_W-1:0];
         ST_WR_S   :
         begin
            mem_bus.idx = s_addr[alut_entry_pkg::AL_IDX_W-1:0];
            mem_bus.wr  = 1'b1;   // learn source, fresh stamp
         end
         ST_AGE_RD : mem_bus.idx = sweep_idx;
         ST_AGE_WR :
         begin
            mem_bus.idx         = sweep_idx;
            mem_bus.wr          = inv_now;
            mem_bus.wdata       = mem_bus.rdata;
            mem_bus.wdata.valid = 1'b0;   // drop aged entry
         end
         default   : ;
      endcase
   end

   a_one_op : assert property (@(posedge pclk1) disable iff (!n_p_reset1)
      !(add_check_active && inval_in_prog));

endmodule

// File: hw/alut_lookup.sv
//----------------------------------------
// alut lookup datapath
// age test and destination port mask for
// the entry read from the table
//----------------------------------------
module alut_lookup
(
   input  alut_entry_pkg::alut_entry_t entry,
   input  alut_entry_pkg::mac_t        d_addr,
   input  alut_entry_pkg::mac_t        mac_addr,
   input  alut_entry_pkg::port_t       s_port,
   input  logic [31:0]                 curr_time,
   input  logic [31:0]                 best_bfr_age,
   output logic                        aged,
   output alut_entry_pkg::dport_t      dport_next
);

   logic [31:0] age;
   logic        hit;

   assign age  = curr_time - entry.stamp;   // mod 2^32, survives wrap
   assign aged = age > best_bfr_age;

   // only a live entry for this dest counts
   assign hit = entry.valid & ~aged & (entry.addr == d_addr);

   always_comb
   begin
      if (d_addr == mac_addr)
         dport_next = alut_entry_pkg::AL_DP_SELF;   // frame for the switch
      else if (hit)
         dport_next = alut_entry_pkg::dport_t'(1) << entry.port;
      else
      begin
         // unknown dest, flood but not back out the source
         dport_next         = alut_entry_pkg::AL_DP_FLOOD;
         dport_next[s_port] = 1'b0;
      end
   end

endmodule

// File: hw/alut_timer.sv
//----------------------------------------
// alut time base
// curr_time steps once every div_clk+1
// pclk1 cycles
//----------------------------------------
module alut_timer
(
   input  logic        pclk1,
   input  logic        n_p_reset1,
   input  logic [7:0]  div_clk,
   output logic [31:0] curr_time
);

   logic [7:0] div_cnt;

   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
      begin
         div_cnt   <= '0;
         curr_time <= '0;
      end
      else if (div_cnt >= div_clk)   // >= copes with divider lowered mid count
      begin
         div_cnt   <= '0;
         curr_time <= curr_time + 32'd1;
      end
      else
         div_cnt <= div_cnt + 8'd1;
   end

endmodule

// File: hw/alut_mem.sv
//----------------------------------------
// alut table memory
// 8 entries, registered read, valid bits
// cleared by reset
//----------------------------------------
module alut_mem
(
   input  logic    pclk1,
   input  logic    n_p_reset1,
   alut_mem_if.mem mem_bus
);

   alut_entry_pkg::alut_entry_t         entries_q [alut_entry_pkg::AL_DEPTH];
   logic [alut_entry_pkg::AL_DEPTH-1:0] valid_q;
   alut_entry_pkg::alut_entry_t         rd_q;
   logic                                rd_valid_q;

   always_ff @(posedge pclk1)
   begin
      if (mem_bus.wr)
         entries_q[mem_bus.idx] <= mem_bus.wdata;
      rd_q <= entries_q[mem_bus.idx];   // old data on same cycle write
   end

   always_ff @(posedge pclk1 or negedge n_p_reset1)
   begin
      if (!n_p_reset1)
      begin
         valid_q    <= '0;
         rd_valid_q <= 1'b0;
      end
      else
      begin
         if (mem_bus.wr)
            valid_q[mem_bus.idx] <= mem_bus.wdata.valid;
         rd_valid_q <= valid_q[mem_bus.idx];
      end
   end

   always_comb
   begin
      mem_bus.rdata       = rd_q;
      mem_bus.rdata.valid = rd_valid_q;   // payload copy of valid not trusted
   end

   a_idx_range : assert property (@(posedge pclk1) disable iff (!n_p_reset1)
      int'(mem_bus.idx) < alut_entry_pkg::AL_DEPTH);

endmodule

// File: hw/alut.sv
//----------------------------------------
// alut top level
// apb programmed address lookup table for
// a 4 port switch
//----------------------------------------
module alut
(
   input  logic        pclk1,
   input  logic        n_p_reset1,
   input  logic        psel,
   input  logic        penable,
   input  logic        pwrite,
   input  logic [6:0]  paddr,
   input  logic [31:0] pwdata,
   output logic [31:0] prdata
);

   logic [1:0]             command;
   alut_entry_pkg::mac_t   d_addr;
   alut_entry_pkg::mac_t   s_addr;
   alut_entry_pkg::mac_t   mac_addr;
   alut_entry_pkg::port_t  s_port;
   logic [31:0]            best_bfr_age;
   logic [7:0]             div_clk;
   logic [31:0]            curr_time;
   logic                   add_check_active;
   logic                   inval_in_prog;
   logic                   reused;
   logic                   clear_reused;
   alut_entry_pkg::mac_t   lst_inv_addr_nrm;
   alut_entry_pkg::port_t  lst_inv_port_nrm;
   alut_entry_pkg::mac_t   lst_inv_addr_cmd;
   alut_entry_pkg::port_t  lst_inv_port_cmd;
   alut_entry_pkg::dport_t d_port;
   alut_entry_pkg::dport_t dport_next;
   logic                   aged;

   alut_mem_if mem_bus ();   // controller to table

   alut_reg_bank reg_bank_inst (
      .pclk1, .n_p_reset1, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata,
      .curr_time, .add_check_active, .inval_in_prog, .reused, .d_port,
      .lst_inv_addr_nrm, .lst_inv_port_nrm, .lst_inv_addr_cmd, .lst_inv_port_cmd,
      .mac_addr, .d_addr, .s_addr, .s_port, .best_bfr_age, .div_clk, .command,
      .clear_reused
   );

   alut_ctrl ctrl_inst (
      .pclk1, .n_p_reset1, .command, .d_addr, .s_addr, .s_port, .best_bfr_age,
      .curr_time, .clear_reused, .dport_next, .aged, .mem_bus(mem_bus.ctrl),
      .add_check_active, .inval_in_prog, .reused, .lst_inv_addr_nrm,
      .lst_inv_port_nrm, .lst_inv_addr_cmd, .lst_inv_port_cmd, .d_port
   );

   // looks at whatever the table returned last
   alut_lookup lookup_inst (
      .entry(mem_bus.rdata), .d_addr, .mac_addr, .s_port, .curr_time,
      .best_bfr_age, .aged, .dport_next
   );

   alut_timer timer_inst (.pclk1, .n_p_reset1, .div_clk, .curr_time);

   alut_mem mem_inst (.pclk1, .n_p_reset1, .mem_bus(mem_bus.mem));

endmodule

// File: dv/alut_tb.sv
//----------------------------------------
// alut testbench
// table of apb writes, reads and commands
// applied to the lookup table top level
//----------------------------------------
module alut_tb;

   typedef enum {K_WR, K_RD, K_CMD, K_TIME} kind_t;

   typedef struct {
      kind_t       kind;
      logic [6:0]  off;
      logic [31:0] data;   // write data or command code
      logic [31:0] exp;    // read value, final status for a command
   } row_t;

   logic        pclk1;
   logic        n_p_reset1;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [6:0]  paddr;
   logic [31:0] pwdata;
   logic [31:0] prdata;

   row_t        rows[$];
   bit          table_ready;
   int          checks;
   int          errors;
   logic [31:0] last_time;   // previous cur_time sample

   alut alut_inst (.pclk1, .n_p_reset1, .psel, .penable, .pwrite, .paddr, .pwdata, .prdata);

   initial
   begin
      pclk1 = 1'b0;
      forever #4 pclk1 = ~pclk1;   // period 8
   end

   //----------------------------------------
   // helpers
   //----------------------------------------
   function automatic string reg_name(input logic [6:0] off);
      case (off)
         alut_reg_pkg::AL_FRM_D_ADDR_L   : return "AL_FRM_D_ADDR_L";
         alut_reg_pkg::AL_FRM_D_ADDR_U   : return "AL_FRM_D_ADDR_U";
         alut_reg_pkg::AL_FRM_S_ADDR_L   : return "AL_FRM_S_ADDR_L";
         alut_reg_pkg::AL_FRM_S_ADDR_U   : return "AL_FRM_S_ADDR_U";
         alut_reg_pkg::AL_S_PORT         : return "AL_S_PORT";
         alut_reg_pkg::AL_D_PORT         : return "AL_D_PORT";
         alut_reg_pkg::AL_MAC_ADDR_L     : return "AL_MAC_ADDR_L";
         alut_reg_pkg::AL_MAC_ADDR_U     : return "AL_MAC_ADDR_U";
         alut_reg_pkg::AL_COMMAND        : return "AL_COMMAND";
         alut_reg_pkg::AL_BB_AGE         : return "AL_BB_AGE";
         alut_reg_pkg::AL_DIV_CLK        : return "AL_DIV_CLK";
         alut_reg_pkg::AL_STATUS         : return "AL_STATUS";
         alut_reg_pkg::AL_CUR_TIME       : return "AL_CUR_TIME";
         alut_reg_pkg::AL_LST_INV_ADDR_L : return "AL_LST_INV_ADDR_L";
         alut_reg_pkg::AL_LST_INV_ADDR_U : return "AL_LST_INV_ADDR_U";
         alut_reg_pkg::AL_LST_INV_PORT   : return "AL_LST_INV_PORT";
         default                         : return "unmapped";
      endcase
   endfunction

   // random address, low bits pick the table slot
   function automatic logic [47:0] rand_mac(input logic [2:0] idx);
      logic [47:0] mac;
      mac      = {16'($urandom), 32'($urandom)};
      mac[2:0] = idx;
      return mac;
   endfunction

   function automatic void add_row(input kind_t k, input logic [6:0] o,
                                   input logic [31:0] d, input logic [31:0] e);
      rows.push_back('{k, o, d, e});
   endfunction

   // write then read back
   function automatic void add_rw(input logic [6:0] o, input logic [31:0] d,
                                  input logic [31:0] e);
      add_row(K_WR, o, d, '0);
      add_row(K_RD, o, '0, e);
   endfunction

   // upper half sits 4 above the lower half
   function automatic void load_mac(input logic [6:0] off_l, input logic [47:0] mac);
      add_row(K_WR, off_l, mac[31:0], '0);
      add_row(K_WR, 7'(off_l + 7'd4), {16'd0, mac[47:32]}, '0);
   endfunction

   function automatic void queue_frame(input logic [47:0] d, input logic [47:0] s,
                                       input logic [1:0] port, input logic [4:0] dport,
                                       input logic [31:0] status);
      load_mac(alut_reg_pkg::AL_FRM_D_ADDR_L, d);
      load_mac(alut_reg_pkg::AL_FRM_S_ADDR_L, s);
      add_row(K_WR, alut_reg_pkg::AL_S_PORT, {30'd0, port}, '0);
      add_row(K_CMD, alut_reg_pkg::AL_COMMAND, {30'd0, alut_reg_pkg::AL_CMD_CHECK}, status);
      add_row(K_RD, alut_reg_pkg::AL_D_PORT, '0, {27'd0, dport});
   endfunction

   //----------------------------------------
   // stimulus table
   //----------------------------------------
   task automatic build_table();
      logic [47:0] mac_a;    // slot 1, port 1
      logic [47:0] mac_a2;   // slot 1, evicts mac_a
      logic [47:0] mac_c;    // slot 3, port 2
      logic [47:0] mac_u;    // slot 5, never learned
      logic [47:0] mac_m;    // switch itself
      logic [6:0]  reset_offs [15];
      logic [31:0] st_reused;
      mac_a  = rand_mac(3'd1);
      mac_a2 = rand_mac(3'd1);
      while (mac_a2 == mac_a)
         mac_a2 = rand_mac(3'd1);
      mac_c     = rand_mac(3'd3);
      mac_u     = rand_mac(3'd5);
      mac_m     = rand_mac(3'd7);
      st_reused = 32'd1 << alut_reg_pkg::AL_ST_REUSED;
      reset_offs = '{alut_reg_pkg::AL_FRM_D_ADDR_L, alut_reg_pkg::AL_FRM_D_ADDR_U,
                     alut_reg_pkg::AL_FRM_S_ADDR_L, alut_reg_pkg::AL_FRM_S_ADDR_U,
                     alut_reg_pkg::AL_S_PORT, alut_reg_pkg::AL_D_PORT,
                     alut_reg_pkg::AL_MAC_ADDR_L, alut_reg_pkg::AL_MAC_ADDR_U,
                     alut_reg_pkg::AL_COMMAND, alut_reg_pkg::AL_BB_AGE,
                     alut_reg_pkg::AL_DIV_CLK, alut_reg_pkg::AL_STATUS,
                     alut_reg_pkg::AL_LST_INV_ADDR_L, alut_reg_pkg::AL_LST_INV_ADDR_U,
                     alut_reg_pkg::AL_LST_INV_PORT};
      // reset values, age all ones
      foreach (reset_offs[i])
         add_row(K_RD, reset_offs[i], '0,
                 (reset_offs[i] == alut_reg_pkg::AL_BB_AGE) ? 32'hffff_ffff : 32'd0);
      // read back, masked to width
      add_rw(alut_reg_pkg::AL_FRM_D_ADDR_L, 32'h1357_9bdf, 32'h1357_9bdf);
      add_rw(alut_reg_pkg::AL_FRM_D_ADDR_U, 32'hffff_2468, 32'h0000_2468);
      add_rw(alut_reg_pkg::AL_FRM_S_ADDR_L, 32'hc0de_5a5a, 32'hc0de_5a5a);
      add_rw(alut_reg_pkg::AL_FRM_S_ADDR_U, 32'h8765_abcd, 32'h0000_abcd);
      add_rw(alut_reg_pkg::AL_S_PORT, 32'hffff_fffe, 32'h0000_0002);
      add_rw(alut_reg_pkg::AL_MAC_ADDR_L, 32'h0f1e_2d3c, 32'h0f1e_2d3c);
      add_rw(alut_reg_pkg::AL_MAC_ADDR_U, 32'h4b5a_6978, 32'h0000_6978);
      add_rw(alut_reg_pkg::AL_COMMAND, 32'hffff_fffc, 32'h0000_0000);   // code 0, no op
      add_rw(alut_reg_pkg::AL_BB_AGE, 32'h1234_5678, 32'h1234_5678);
      add_rw(alut_reg_pkg::AL_DIV_CLK, 32'h0000_01a5, 32'h0000_00a5);
      add_rw(alut_reg_pkg::AL_BB_AGE, 32'hffff_ffff, 32'hffff_ffff);
      add_rw(alut_reg_pkg::AL_DIV_CLK, 32'h0, 32'h0);   // time steps every cycle
      add_row(K_TIME, alut_reg_pkg::AL_CUR_TIME, '0, '0);
      add_row(K_TIME, alut_reg_pkg::AL_CUR_TIME, '0, '0);
      // learn and look up
      load_mac(alut_reg_pkg::AL_MAC_ADDR_L, mac_m);
      queue_frame(mac_u, mac_a, 2'd1, 5'b01101, 32'd0);   // flood, not port 1
      queue_frame(mac_a, mac_c, 2'd2, 5'b00010, 32'd0);   // hit on port 1
      queue_frame(mac_u, mac_c, 2'd2, 5'b01011, 32'd0);   // flood, not port 2
      queue_frame(mac_m, mac_c, 2'd2, 5'b10000, 32'd0);   // to the switch
      // reuse of slot 1
      queue_frame(mac_u, mac_a2, 2'd3, 5'b00111, st_reused);
      add_row(K_RD, alut_reg_pkg::AL_LST_INV_ADDR_L, '0, mac_a[31:0]);
      add_row(K_RD, alut_reg_pkg::AL_LST_INV_ADDR_U, '0, {16'd0, mac_a[47:32]});
      add_row(K_RD, alut_reg_pkg::AL_LST_INV_PORT, '0, 32'd1);
      add_row(K_RD, alut_reg_pkg::AL_STATUS, '0, 32'd0);   // flag acknowledged
      // sweep with max age keeps everything
      add_row(K_CMD, alut_reg_pkg::AL_COMMAND, {30'd0, alut_reg_pkg::AL_CMD_AGE}, 32'd0);
      queue_frame(mac_a2, mac_c, 2'd2, 5'b01000, 32'd0);   // still hits port 3
      add_row(K_TIME, alut_reg_pkg::AL_CUR_TIME, '0, '0);
      add_row(K_TIME, alut_reg_pkg::AL_CUR_TIME, '0, '0);
      // zero age, sweep drops slots 1 and 3
      add_rw(alut_reg_pkg::AL_BB_AGE, 32'h0, 32'h0);
      add_row(K_CMD, alut_reg_pkg::AL_COMMAND, {30'd0, alut_reg_pkg::AL_CMD_AGE}, 32'd0);
      add_row(K_RD, alut_reg_pkg::AL_LST_INV_ADDR_L, '0, mac_c[31:0]);
      add_row(K_RD, alut_reg_pkg::AL_LST_INV_ADDR_U, '0, {16'd0, mac_c[47:32]});
      add_row(K_RD, alut_reg_pkg::AL_LST_INV_PORT, '0, 32'd2);
      queue_frame(mac_c, mac_a2, 2'd3, 5'b00111, 32'd0);   // mac_c gone, floods
   endtask

   //----------------------------------------
   // apb transfers, one idle cycle after each
   //----------------------------------------
   task automatic apb_write(input logic [6:0] addr, input logic [31:0] data);
      @(posedge pclk1);
      #1;
      psel    = 1'b1;
      pwrite  = 1'b1;
      penable = 1'b0;
      paddr   = addr;
      pwdata  = data;
      @(posedge pclk1);
      #1;
      penable = 1'b1;
      @(posedge pclk1);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   task automatic apb_read(input logic [6:0] addr, output logic [31:0] data);
      @(posedge pclk1);
      #1;
      psel    = 1'b1;
      pwrite  = 1'b0;
      penable = 1'b0;
      paddr   = addr;
      @(posedge pclk1);
      #1;
      penable = 1'b1;
      data    = prdata;   // registered in setup
      @(posedge pclk1);
      #1;
      psel    = 1'b0;
      penable = 1'b0;
      checks++;
      if (prdata !== 32'd0)   // back to zero after access
      begin
         errors++;
         $display("Fail at %0t: prdata expected %h read %h", $time, 32'd0, prdata);
      end
   endtask

   // wait for the operation to start, then to finish
   task automatic poll_status(output logic [31:0] status, output bit done);
      bit seen_busy;
      int n;
      seen_busy = 1'b0;
      done      = 1'b0;
      status    = '0;
      for (n = 0; n < 64 && !done; n++)
      begin
         apb_read(alut_reg_pkg::AL_STATUS, status);
         if (status[alut_reg_pkg::AL_ST_ACTIVE] || status[alut_reg_pkg::AL_ST_INVAL])
            seen_busy = 1'b1;
         else if (seen_busy)
            done = 1'b1;
      end
   endtask

   //----------------------------------------
   // watchdog
   //----------------------------------------
   initial
   begin
      longint limit;
      wait (table_ready);
      limit = longint'(rows.size()) * 64 * 8 * 8;
      #(limit);
      $display("watchdog expired before the table was done");
      $display("Test FAILED");
      $finish;
   end

   //----------------------------------------
   // main
   //----------------------------------------
   initial
   begin
      row_t        r;
      logic [31:0] got;
      bit          ok;
      void'($urandom(32'hfd35_a971));
      n_p_reset1 = 1'b0;
      psel       = 1'b0;
      penable    = 1'b0;
      pwrite     = 1'b0;
      paddr      = '0;
      pwdata     = '0;
      checks     = 0;
      errors     = 0;
      last_time  = '0;
      build_table();
      table_ready = 1'b1;
      repeat (10) @(posedge pclk1);
      #1 n_p_reset1 = 1'b1;
      checks++;
      if (prdata !== 32'd0)
      begin
         errors++;
         $display("Fail at %0t: prdata expected %h read %h", $time, 32'd0, prdata);
      end
      foreach (rows[i])
      begin
         r = rows[i];
         case (r.kind)
            K_WR : apb_write(r.off, r.data);
            K_RD :
            begin
               apb_read(r.off, got);
               checks++;
               if (got !== r.exp)
               begin
                  errors++;
                  $display("Fail at %0t: %s expected %h read %h",
                           $time, reg_name(r.off), r.exp, got);
               end
            end
            K_TIME :
            begin
               apb_read(r.off, got);
               checks++;
               if (got <= last_time)   // must keep counting
               begin
                  errors++;
                  $display("Fail at %0t: %s expected above %h read %h",
                           $time, reg_name(r.off), last_time, got);
               end
               last_time = got;
            end
            default :
            begin
               apb_write(r.off, r.data);
               poll_status(got, ok);
               checks++;
               if (!ok)
               begin
                  errors++;
                  $display("command %0d in row %0d never started and finished", r.data, i);
               end
               else if (got !== r.exp)
               begin
                  errors++;
                  $display("Fail at %0t: %s expected %h read %h",
                           $time, reg_name(alut_reg_pkg::AL_STATUS), r.exp, got);
               end
            end
         endcase
      end
      @(posedge pclk1);
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// File: alut.f
hw/alut_reg_pkg.sv
hw/alut_entry_pkg.sv
hw/alut_mem_if.sv
hw/alut_reg_bank.sv
hw/alut_ctrl.sv
hw/alut_lookup.sv
hw/alut_timer.sv
hw/alut_mem.sv
hw/alut.sv
dv/alut_tb.sv
